// File: source/user_io_defines.svh
`ifndef USER_IO_DEFINES_SVH
`define USER_IO_DEFINES_SVH

// one serial byte on the link
`define UIO_BYTE_W 8

// four directions plus two fire buttons
`define UIO_JOY_W 6

// returned msb first on miso while the command byte comes in
`define UIO_CORE_TYPE 8'hc6

// byte index saturates here and later bytes reuse it
`define UIO_MAX_INDEX 7

`endif

// File: source/user_io_pkg.sv
`include "user_io_defines.svh"

package user_io_pkg;

   // enough bits to number every byte up to the saturation index
   localparam int idx_w = $clog2(`UIO_MAX_INDEX + 1);

   // first byte of a frame
   typedef enum logic [7:0] {
      cmd_none     = 8'd0,
      cmd_buttons  = 8'd1,
      cmd_joy0     = 8'd2,
      cmd_joy1     = 8'd3,
      cmd_mouse    = 8'd4,
      cmd_keyboard = 8'd5,
      cmd_osd_kbd  = 8'd6
   } cmd_e;

   typedef enum logic [1:0] {
      kms_mouse_x = 2'd0,
      kms_mouse_y = 2'd1,
      kms_keycode = 2'd2,
      kms_osd_key = 2'd3
   } kms_type_e;

   typedef struct packed {
      logic [`UIO_BYTE_W-1:0] data;
      logic [idx_w-1:0]       index;  // 0 = command byte
      logic                   valid;  // one cycle per byte
   } spi_byte_t;

   // same bit order as the payload byte
   typedef struct packed {
      logic [3:0] conf;
      logic [1:0] switches;
      logic [1:0] buttons;
   } user_sw_t;

   typedef struct packed {
      kms_type_e              kind;
      logic [`UIO_BYTE_W-1:0] data;
   } kbd_mouse_t;

endpackage

// File: source/spi_byte_rx.sv
`timescale 1ns/1ps
`include "user_io_defines.svh"

module spi_byte_rx (
   input  logic                   SPI_CLK,
   input  logic                   rst,
   input  logic                   spi_ss,    // high ends the frame
   input  logic                   spi_mosi,
   output logic                   spi_miso,
   output user_io_pkg::spi_byte_t rx_byte
);

   localparam int bit_w = $clog2(`UIO_BYTE_W);
   localparam int idx_w = user_io_pkg::idx_w;
   localparam logic [`UIO_BYTE_W-1:0] core_type = `UIO_CORE_TYPE;

   logic [bit_w-1:0]        bit_cnt;
   logic [idx_w-1:0]        byte_idx;
   logic [`UIO_BYTE_W-2:0]  sbuf;       // first seven bits of the byte
   logic                    last_bit;
   logic                    byte_done;
   logic                    valid_q;
   logic [`UIO_BYTE_W-1:0]  data_q;
   logic [idx_w-1:0]        index_q;

   assign last_bit = (bit_cnt == bit_w'(`UIO_BYTE_W - 1));

   // counters and strobe
   always_ff @(posedge SPI_CLK) begin
      if (rst) begin
         bit_cnt   <= '0;
         byte_idx  <= '0;
         byte_done <= 1'b0;
         valid_q   <= 1'b0;
      end else if (spi_ss) begin
         bit_cnt   <= '0;     // a partial byte is dropped here
         byte_idx  <= '0;
         byte_done <= 1'b0;
         valid_q   <= 1'b0;
      end else begin
         bit_cnt   <= bit_cnt + 1'b1;
         byte_done <= last_bit;
         valid_q   <= byte_done;   // one edge after the eighth bit
         if (last_bit && byte_idx != idx_w'(`UIO_MAX_INDEX)) begin
            byte_idx <= byte_idx + 1'b1;
         end
      end
   end

   // shifter, byte captured with the eighth bit still on mosi
   always_ff @(posedge SPI_CLK) begin
      if (!spi_ss) begin
         sbuf <= {sbuf[`UIO_BYTE_W-3:0], spi_mosi};
         if (last_bit) begin
            data_q  <= {sbuf, spi_mosi};
            index_q <= byte_idx;
         end
      end
   end

   // data and index only change at the next byte end, so they hold through valid
   assign rx_byte = '{data: data_q, index: index_q, valid: valid_q};

   // core type goes out on the falling edge ahead of each sampling edge
   always_ff @(negedge SPI_CLK) begin
      if (rst) begin
         spi_miso <= 1'b0;
      end else if (!spi_ss && byte_idx == '0) begin
         spi_miso <= core_type[~bit_cnt];   // msb first
      end else begin
         spi_miso <= 1'b0;
      end
   end

endmodule

// File: source/user_io_cmd.sv
`timescale 1ns/1ps
`include "user_io_defines.svh"

module user_io_cmd (
   input  logic                    SPI_CLK,
   input  logic                    rst,
   input  user_io_pkg::spi_byte_t  rx_byte,
   output user_io_pkg::user_sw_t   sw,
   output logic [`UIO_JOY_W-1:0]   joy0,
   output logic [`UIO_JOY_W-1:0]   joy1,
   output logic [2:0]              mouse_buttons,
   output user_io_pkg::kbd_mouse_t kms,
   output logic                    kms_strobe,   // one cycle per event byte
   output logic                    kms_level     // flips after every strobe
);

   localparam int idx_w = user_io_pkg::idx_w;

   user_io_pkg::cmd_e cmd;
   user_io_pkg::cmd_e rx_cmd;

   // unknown values fall back to cmd_none
   function automatic user_io_pkg::cmd_e to_cmd(input logic [`UIO_BYTE_W-1:0] b);
      user_io_pkg::cmd_e c;
      case (b)
         8'd1:    c = user_io_pkg::cmd_buttons;
         8'd2:    c = user_io_pkg::cmd_joy0;
         8'd3:    c = user_io_pkg::cmd_joy1;
         8'd4:    c = user_io_pkg::cmd_mouse;
         8'd5:    c = user_io_pkg::cmd_keyboard;
         8'd6:    c = user_io_pkg::cmd_osd_kbd;
         default: c = user_io_pkg::cmd_none;
      endcase
      return c;
   endfunction

   assign rx_cmd = to_cmd(rx_byte.data);

   always_ff @(posedge SPI_CLK) begin
      if (rst) begin
         cmd           <= user_io_pkg::cmd_none;
         sw            <= '0;
         joy0          <= '0;
         joy1          <= '0;
         mouse_buttons <= '0;
         kms           <= '0;
         kms_strobe    <= 1'b0;
         kms_level     <= 1'b0;
      end else begin
         kms_strobe <= 1'b0;
         kms_level  <= kms_level ^ kms_strobe;

         if (rx_byte.valid) begin
            case (rx_byte.index)
               idx_w'(0): begin
                  cmd <= rx_cmd;
                  // event type follows the command right away
                  case (rx_cmd)
                     user_io_pkg::cmd_mouse:    kms.kind <= user_io_pkg::kms_mouse_x;
                     user_io_pkg::cmd_keyboard: kms.kind <= user_io_pkg::kms_keycode;
                     user_io_pkg::cmd_osd_kbd:  kms.kind <= user_io_pkg::kms_osd_key;
                     default: ;
                  endcase
               end

               idx_w'(1): begin
                  case (cmd)
                     user_io_pkg::cmd_buttons: begin
                        sw <= user_io_pkg::user_sw_t'(rx_byte.data);
                     end
                     user_io_pkg::cmd_joy0: begin
                        joy0 <= rx_byte.data[`UIO_JOY_W-1:0];
                     end
                     user_io_pkg::cmd_joy1: begin
                        joy1 <= rx_byte.data[`UIO_JOY_W-1:0];
                     end
                     user_io_pkg::cmd_mouse,
                     user_io_pkg::cmd_keyboard,
                     user_io_pkg::cmd_osd_kbd: begin
                        kms.data   <= rx_byte.data;   // kind set with the command
                        kms_strobe <= 1'b1;
                     end
                     default: ;
                  endcase
               end

               idx_w'(2): begin
                  if (cmd == user_io_pkg::cmd_mouse) begin
                     kms.kind   <= user_io_pkg::kms_mouse_y;   // second axis
                     kms.data   <= rx_byte.data;
                     kms_strobe <= 1'b1;
                  end
               end

               idx_w'(3): begin
                  if (cmd == user_io_pkg::cmd_mouse) begin
                     mouse_buttons <= rx_byte.data[2:0];
                  end
               end

               default: ;   // trailing bytes ignored
            endcase
         end
      end
   end

endmodule

// File: source/user_io_top.sv
`timescale 1ns/1ps
`include "user_io_defines.svh"

module user_io_top (
   input  logic                    SPI_CLK,
   input  logic                    rst,
   input  logic                    spi_ss,
   input  logic                    spi_mosi,
   output logic                    spi_miso,
   output user_io_pkg::user_sw_t   sw,
   output logic [`UIO_JOY_W-1:0]   joy0,
   output logic [`UIO_JOY_W-1:0]   joy1,
   output logic [2:0]              mouse_buttons,
   output user_io_pkg::kbd_mouse_t kms,
   output logic                    kms_strobe,
   output logic                    kms_level
);

   user_io_pkg::spi_byte_t rx_byte;   // one strobe per received byte

   // serial side, returns the core type on miso
   spi_byte_rx i_spi_byte_rx (
      .SPI_CLK  (SPI_CLK),
      .rst      (rst),
      .spi_ss   (spi_ss),
      .spi_mosi (spi_mosi),
      .spi_miso (spi_miso),
      .rx_byte  (rx_byte)
   );

   // register side, one cycle behind the byte strobe
   user_io_cmd i_user_io_cmd (
      .SPI_CLK       (SPI_CLK),
      .rst           (rst),
      .rx_byte       (rx_byte),
      .sw            (sw),
      .joy0          (joy0),
      .joy1          (joy1),
      .mouse_buttons (mouse_buttons),
      .kms           (kms),
      .kms_strobe    (kms_strobe),
      .kms_level     (kms_level)
   );

endmodule

// File: sim/user_io_checker.sv
`timescale 1ns/1ps

module user_io_checker (
   input logic                          SPI_CLK,
   input logic                          rst,
   input logic                          spi_ss,
   input logic                          spi_miso,
   input logic [user_io_pkg::idx_w-1:0] byte_idx,
   input user_io_pkg::spi_byte_t        rx_byte,
   input logic                          kms_strobe,
   input logic                          kms_level
);

   int fail_count = 0;   // failure tally watched by the testbench

   strobe_single: assert property (@(posedge SPI_CLK) disable iff (rst)
      kms_strobe |=> !kms_strobe)
      else begin
         $error("kms_strobe held for two cycles");
         fail_count++;
      end

   // level flips exactly one cycle after each strobe and never otherwise
   level_follows_strobe: assert property (@(posedge SPI_CLK) disable iff (rst)
      (kms_level != $past(kms_level)) == $past(kms_strobe))
      else begin
         $error("kms_level did not track kms_strobe");
         fail_count++;
      end

   no_valid_deselected: assert property (@(posedge SPI_CLK) disable iff (rst)
      spi_ss |-> !rx_byte.valid)
      else begin
         $error("byte strobe while select is high");
         fail_count++;
      end

   miso_quiet: assert property (@(posedge SPI_CLK) disable iff (rst)
      (byte_idx != '0) |-> !spi_miso)
      else begin
         $error("miso high outside the command byte");
         fail_count++;
      end

endmodule

// serial side with the event outputs tied off
bind spi_byte_rx user_io_checker i_rx_check (
   .SPI_CLK    (SPI_CLK),
   .rst        (rst),
   .spi_ss     (spi_ss),
   .spi_miso   (spi_miso),
   .byte_idx   (byte_idx),
   .rx_byte    (rx_byte),
   .kms_strobe (1'b0),
   .kms_level  (1'b0)
);

// decoder side with the serial signals tied off
bind user_io_cmd user_io_checker i_cmd_check (
   .SPI_CLK    (SPI_CLK),
   .rst        (rst),
   .spi_ss     (1'b0),
   .spi_miso   (1'b0),
   .byte_idx   ('0),
   .rx_byte    (rx_byte),
   .kms_strobe (kms_strobe),
   .kms_level  (kms_level)
);

// File: sim/user_io_tb.sv
`timescale 1ns/1ps
`include "user_io_defines.svh"

module user_io_tb;

   localparam int num_frames     = 9;
   localparam int clk_period     = 100;
   localparam int timeout_cycles = num_frames * 40 + 40;   // reset plus margin

   logic                    SPI_CLK;
   logic                    rst;
   logic                    spi_ss;
   logic                    spi_mosi;
   logic                    spi_miso;
   user_io_pkg::user_sw_t   sw;
   logic [`UIO_JOY_W-1:0]   joy0;
   logic [`UIO_JOY_W-1:0]   joy1;
   logic [2:0]              mouse_buttons;
   user_io_pkg::kbd_mouse_t kms;
   logic                    kms_strobe;
   logic                    kms_level;

   // expected register state
   user_io_pkg::user_sw_t   exp_sw;
   logic [`UIO_JOY_W-1:0]   exp_joy0;
   logic [`UIO_JOY_W-1:0]   exp_joy1;
   logic [2:0]              exp_mbtn;
   user_io_pkg::kbd_mouse_t exp_kms;
   logic                    exp_level;

   user_io_pkg::kbd_mouse_t events[$];   // one entry per strobe

   user_io_top i_user_io_top (
      .SPI_CLK       (SPI_CLK),
      .rst           (rst),
      .spi_ss        (spi_ss),
      .spi_mosi      (spi_mosi),
      .spi_miso      (spi_miso),
      .sw            (sw),
      .joy0          (joy0),
      .joy1          (joy1),
      .mouse_buttons (mouse_buttons),
      .kms           (kms),
      .kms_strobe    (kms_strobe),
      .kms_level     (kms_level)
   );

   initial SPI_CLK = 1'b0;
   always #(clk_period / 2) SPI_CLK = ~SPI_CLK;

   // strobe monitor sampled mid cycle
   always @(negedge SPI_CLK) begin
      if (!rst && kms_strobe) begin
         events.push_back(kms);
      end
   end

   // a failed assertion in either bound checker ends the run at once
   always @(i_user_io_top.i_spi_byte_rx.i_rx_check.fail_count
            or i_user_io_top.i_user_io_cmd.i_cmd_check.fail_count) begin
      if (i_user_io_top.i_spi_byte_rx.i_rx_check.fail_count
          + i_user_io_top.i_user_io_cmd.i_cmd_check.fail_count != 0) begin
         $display("Error: a protocol assertion failed");
         abort_run();
      end
   end

   initial begin
      #(timeout_cycles * clk_period);
      $display("Error: the frames did not finish within %0d clock periods", timeout_cycles);
      abort_run();
   end

   task automatic abort_run();
      $display("Done: errors found");
      $fatal(1, "run stopped at the first error");
   endtask

   task automatic compare_bits(input string name, input logic [`UIO_BYTE_W-1:0] exp,
                               input logic [`UIO_BYTE_W-1:0] act);
      if (act !== exp) begin
         $display("Mismatch in %s: expected %h, actual %h", name, exp, act);
         abort_run();
      end
   endtask

   task automatic compare_sw(input string name, input user_io_pkg::user_sw_t exp,
                             input user_io_pkg::user_sw_t act);
      if (act !== exp) begin
         $display("Mismatch in %s: expected %h, actual %h", name, exp, act);
         abort_run();
      end
   endtask

   task automatic compare_joy(input string name, input logic [`UIO_JOY_W-1:0] exp,
                              input logic [`UIO_JOY_W-1:0] act);
      if (act !== exp) begin
         $display("Mismatch in %s: expected %h, actual %h", name, exp, act);
         abort_run();
      end
   endtask

   task automatic compare_event(input string name, input user_io_pkg::kbd_mouse_t exp,
                                input user_io_pkg::kbd_mouse_t act);
      if (act !== exp) begin
         $display("Mismatch in %s: expected kind %0d data %h, actual kind %0d data %h",
                  name, exp.kind, exp.data, act.kind, act.data);
         abort_run();
      end
   endtask

   task automatic check_outputs(input string name);
      compare_sw({name, " sw"}, exp_sw, sw);
      compare_joy({name, " joy0"}, exp_joy0, joy0);
      compare_joy({name, " joy1"}, exp_joy1, joy1);
      compare_bits({name, " mouse buttons"}, {5'd0, exp_mbtn}, {5'd0, mouse_buttons});
      compare_event({name, " kms"}, exp_kms, kms);
      compare_bits({name, " kms_level"}, {7'd0, exp_level}, {7'd0, kms_level});
   endtask

   // msb first with miso captured on the edge that samples each bit
   task automatic send_byte(input logic [7:0] b, input int nbits, output logic [7:0] miso_bits);
      logic [7:0] sh;
      sh = b;
      miso_bits = '0;
      for (int n = 0; n < nbits; n++) begin
         spi_mosi <= sh[7];
         sh = sh << 1;
         @(posedge SPI_CLK);
         miso_bits = {miso_bits[6:0], spi_miso};
      end
   endtask

   task automatic send_frame(input logic [7:0] cmd_b, input logic [7:0] b1,
                             input logic [7:0] b2, input logic [7:0] b3,
                             input int n_payload, input int last_bits);
      logic [31:0] frame_bits;
      logic [7:0]  miso_bits;
      int          nbits;
      frame_bits = {cmd_b, b1, b2, b3};
      @(posedge SPI_CLK);
      spi_ss <= 1'b0;
      for (int k = 0; k <= n_payload; k++) begin
         nbits = (k == n_payload) ? last_bits : 8;
         send_byte(frame_bits[31:24], nbits, miso_bits);
         frame_bits = frame_bits << 8;
         if (k == 0 && nbits == 8) begin
            compare_bits("core type on miso", `UIO_CORE_TYPE, miso_bits);
         end
      end
      spi_mosi <= 1'b0;
      repeat (2) @(posedge SPI_CLK);   // let the last byte reach the registers
      spi_ss <= 1'b1;
      @(posedge SPI_CLK);
      @(negedge SPI_CLK);
   endtask

   task automatic reset_values();
      exp_sw    = '0;
      exp_joy0  = '0;
      exp_joy1  = '0;
      exp_mbtn  = '0;
      exp_kms   = '0;
      exp_level = 1'b0;
      check_outputs("reset");
      compare_bits("reset miso", 8'd0, {7'd0, spi_miso});
      compare_bits("reset kms_strobe", 8'd0, {7'd0, kms_strobe});
   endtask

   task automatic buttons_frame();
      logic [7:0] p;
      p = 8'($urandom);
      send_frame(user_io_pkg::cmd_buttons, p, 8'd0, 8'd0, 1, 8);
      exp_sw = '{conf: p[7:4], switches: p[3:2], buttons: p[1:0]};
      check_outputs("buttons");
   endtask

   task automatic joystick_frames();
      logic [7:0] p;
      p = 8'($urandom);
      send_frame(user_io_pkg::cmd_joy0, p, 8'd0, 8'd0, 1, 8);
      exp_joy0 = p[`UIO_JOY_W-1:0];
      check_outputs("joystick 0");
      p = 8'($urandom);
      send_frame(user_io_pkg::cmd_joy1, p, 8'd0, 8'd0, 1, 8);
      exp_joy1 = p[`UIO_JOY_W-1:0];   // joy0 must hold
      check_outputs("joystick 1");
   endtask

   task automatic key_frames();
      logic [7:0] k;
      k = 8'($urandom);
      events.delete();
      send_frame(user_io_pkg::cmd_keyboard, k, 8'd0, 8'd0, 1, 8);
      exp_kms   = '{kind: user_io_pkg::kms_keycode, data: k};
      exp_level = ~exp_level;
      compare_bits("keyboard strobes", 8'd1, 8'(events.size()));
      compare_event("keyboard event", exp_kms, events[0]);
      check_outputs("keyboard");
      k = 8'($urandom);
      events.delete();
      send_frame(user_io_pkg::cmd_osd_kbd, k, 8'd0, 8'd0, 1, 8);
      exp_kms   = '{kind: user_io_pkg::kms_osd_key, data: k};
      exp_level = ~exp_level;
      compare_bits("osd strobes", 8'd1, 8'(events.size()));
      compare_event("osd event", exp_kms, events[0]);
      check_outputs("osd");
   endtask

   task automatic mouse_frame();
      logic [7:0] x;
      logic [7:0] y;
      logic [7:0] b;
      x = 8'($urandom);
      y = 8'($urandom);
      b = 8'($urandom);
      events.delete();
      send_frame(user_io_pkg::cmd_mouse, x, y, b, 3, 8);
      compare_bits("mouse strobes", 8'd2, 8'(events.size()));
      compare_event("mouse x event", '{kind: user_io_pkg::kms_mouse_x, data: x}, events[0]);
      compare_event("mouse y event", '{kind: user_io_pkg::kms_mouse_y, data: y}, events[1]);
      exp_kms  = '{kind: user_io_pkg::kms_mouse_y, data: y};
      // two toggles leave the level where it was
      exp_mbtn = b[2:0];
      check_outputs("mouse");
   endtask

   task automatic ignored_frames();
      logic [7:0] c;
      logic [7:0] p;
      c = 8'($urandom_range(255, 7));
      p = 8'($urandom);
      events.delete();
      send_frame(c, p, 8'd0, 8'd0, 1, 8);
      compare_bits("unknown command strobes", 8'd0, 8'(events.size()));
      check_outputs("unknown command");
      p = 8'($urandom);
      send_frame(user_io_pkg::cmd_buttons, p, 8'd0, 8'd0, 1, 4);   // cut after four bits
      compare_bits("cut frame strobes", 8'd0, 8'(events.size()));
      check_outputs("cut frame");
      p = 8'($urandom);
      send_frame(user_io_pkg::cmd_buttons, p, 8'd0, 8'd0, 1, 8);
      exp_sw = '{conf: p[7:4], switches: p[3:2], buttons: p[1:0]};
      check_outputs("after cut frame");
   endtask

   initial begin
      void'($urandom(34));
      rst      = 1'b1;
      spi_ss   = 1'b1;
      spi_mosi = 1'b0;
      repeat (3) @(posedge SPI_CLK);
      rst <= 1'b0;
      @(negedge SPI_CLK);
      reset_values();
      buttons_frame();
      joystick_frames();
      key_frames();
      mouse_frame();
      ignored_frames();
      if (i_user_io_top.i_spi_byte_rx.i_rx_check.fail_count
          + i_user_io_top.i_user_io_cmd.i_cmd_check.fail_count == 0) begin
         $display("Done: no errors");
      end else begin
         $display("Done: errors found");
      end
      $finish;
   end

endmodule

// File: tb.f
+incdir+source
source/user_io_pkg.sv
source/spi_byte_rx.sv
source/user_io_cmd.sv
source/user_io_top.sv
sim/user_io_checker.sv
sim/user_io_tb.sv

// File: Makefile
BIN := obj_dir/Vuser_io_tb

all: run

$(BIN): tb.f source/user_io_defines.svh source/user_io_pkg.sv source/spi_byte_rx.sv \
        source/user_io_cmd.sv source/user_io_top.sv sim/user_io_checker.sv sim/user_io_tb.sv
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module user_io_tb -f tb.f -Mdir obj_dir -o Vuser_io_tb

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx 'Done: no errors'

clean:
	rm -rf obj_dir

.PHONY: all run clean
